//--- verilog.f
hdl/clk_mgmt_cfg_pkg.sv
hdl/clk_mgmt_cmd_pkg.sv
hdl/dcm_job_if.sv
hdl/clk_cmd_issuer.sv
hdl/clk_cmd_fifo.sv
hdl/dcm_cmd_dispatch.sv
hdl/dcm_phase_stepper.sv
hdl/dcm_clkgen_loader.sv
hdl/clk_mgmt_ctrl_top.sv
tb/clk_mgmt_assert.sv
tb/tb_clk_mgmt.sv

//--- Bender.yml
package:
  name: clk_mgmt_ctrl

sources:
  - hdl/clk_mgmt_cfg_pkg.sv
  - hdl/clk_mgmt_cmd_pkg.sv
  - hdl/dcm_job_if.sv
  - hdl/clk_cmd_issuer.sv
  - hdl/clk_cmd_fifo.sv
  - hdl/dcm_cmd_dispatch.sv
  - hdl/dcm_phase_stepper.sv
  - hdl/dcm_clkgen_loader.sv
  - hdl/clk_mgmt_ctrl_top.sv
  - target: test
    files:
      - tb/clk_mgmt_assert.sv
      - tb/tb_clk_mgmt.sv

//--- tb/tb_clk_mgmt.sv
module tb_clk_mgmt;
    import clk_mgmt_cfg_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int PSDONE_TIMEOUT = 64;
    localparam int NUM_ROWS       = 9;
    localparam int ROW_CYCLES     = 512 * 8 + 64;       // longest job plus margin
    localparam int QUIET_CYCLES   = 40;                 // clkgen sequence, progdone reply and margin
    localparam int OP_PHASE       = 0;
    localparam int OP_CLKGEN      = 1;
    localparam int OP_BADCG       = 2;                  // m/d outside the dcm limits
    localparam int OP_BOTH        = 3;                  // phase and clkgen in one cycle
    localparam int OP_BURST       = 4;                  // FIFO_DEPTH+2 phase loads

    typedef struct packed {
        int op;
        int ph;                                         // phase target, burst base
        int mul;
        int dv;
        bit ovf;                                        // hold ps_overflow high
        bit hold;                                       // dcm withholds psdone
        int exp_ph;
        int exp_d;
        int exp_m;
        int exp_err;                                    // cmd_error pulses expected
    } row_t;

    logic     clk;
    logic     reset;
    logic     phase_load;
    phase_w_t phase_req;
    logic     clkgen_load;
    md_w_t    mul;
    md_w_t    dv;
    logic     psdone;
    logic     ps_ovf;
    logic     progdone;
    phase_w_t phase_actual;
    logic     phase_done, clkgen_done, cmd_error, busy;
    logic     psen, psincdec, progen, progdata;

    row_t        rows [NUM_ROWS];
    bit          hold_psdone;
    int unsigned lcg_state;
    int          ps_wait, pd_wait, run_len;
    logic [9:0]  prog_bits;                             // lead-in plus word, lsb first
    int          up_steps, dn_steps, prog_cycles, go_cnt, d_word, m_word;
    int          ph_done_cnt, cg_done_cnt, err_cnt;
    time         ph_done_t, cg_done_t;
    int          check_fails, tests_failed;
    bit          row_bad;

    clk_mgmt_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .PSDONE_TIMEOUT(PSDONE_TIMEOUT)) dut_i (
        .clk_i             (clk),
        .reset_i           (reset),
        .phase_load_i      (phase_load),
        .phase_requested_i (phase_req),
        .clkgen_load_i     (clkgen_load),
        .clkgen_mul_i      (mul),
        .clkgen_div_i      (dv),
        .dcm_psdone_i      (psdone),
        .dcm_ps_overflow_i (ps_ovf),
        .dcm_progdone_i    (progdone),
        .phase_actual_o    (phase_actual),
        .phase_done_o      (phase_done),
        .clkgen_done_o     (clkgen_done),
        .cmd_error_o       (cmd_error),
        .busy_o            (busy),
        .dcm_psen_o        (psen),
        .dcm_psincdec_o    (psincdec),
        .dcm_progen_o      (progen),
        .dcm_progdata_o    (progdata)
    );

    always #50 clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // dcm model, samples mid-cycle and drives its replies on the falling edge
    always @(negedge clk) begin
        psdone   = 1'b0;
        progdone = 1'b0;
        if (ps_wait != 0) begin
            ps_wait = ps_wait - 1;
            if (ps_wait == 0) psdone = 1'b1;
        end
        if (psen) begin
            if (psincdec) up_steps++;
            else          dn_steps++;
            if (!hold_psdone) begin
                lcg_state = lcg_next(lcg_state);
                ps_wait   = 1 + (lcg_state >> 16) % 6;  // 1 to 6 cycles
            end
        end
        if (pd_wait != 0) begin
            pd_wait = pd_wait - 1;
            if (pd_wait == 0) progdone = 1'b1;
        end
        if (progen) begin
            if (run_len < 10) prog_bits[run_len] = progdata;
            run_len++;
            prog_cycles++;
        end else if (run_len != 0) begin
            if (run_len == 10 && prog_bits[1:0] == LEAD_D) d_word = prog_bits[9:2];
            else if (run_len == 10 && prog_bits[1:0] == LEAD_M) m_word = prog_bits[9:2];
            else if (run_len == 1) begin
                go_cnt++;
                pd_wait = 3;                            // progdone 4 cycles after go
            end
            run_len = 0;
        end
    end

    // pulse counters, registered outputs seen before they update
    always @(posedge clk) begin
        if (phase_done) begin
            ph_done_cnt++;
            ph_done_t = $time;
        end
        if (clkgen_done) begin
            cg_done_cnt++;
            cg_done_t = $time;
        end
        if (cmd_error) err_cnt++;
    end

    task automatic compare(input string what, input logic signed [31:0] got,
                           input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            check_fails++;
            row_bad = 1'b1;
        end
    endtask

    task automatic wait_counts(input int ph, input int cg, input int er, output bit ok);
        int n;
        n = 0;
        while ((ph_done_cnt < ph || cg_done_cnt < cg || err_cnt < er) && n < ROW_CYCLES) begin
            @(negedge clk);
            n++;
        end
        ok = (ph_done_cnt >= ph && cg_done_cnt >= cg && err_cnt >= er);
    endtask

    initial begin
        #(100 * (NUM_ROWS * ROW_CYCLES + 20));
        $display("watchdog expired, the run took longer than its test budget");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        row_t r;
        int   ph0, cg0, er0, up0, dn0, pc0, go0;
        int   model_ph, want_ph, want_cg, asrt;
        bit   ok;
        clk = 1'b0;
        reset = 1'b1;
        phase_load = 1'b0;
        phase_req = '0;
        clkgen_load = 1'b0;
        mul = '0;
        dv = '0;
        ps_ovf = 1'b0;
        psdone = 1'b0;
        progdone = 1'b0;
        hold_psdone = 1'b0;
        lcg_state = 30;                                 // fixed seed
        {ps_wait, pd_wait, run_len, prog_bits} = '0;
        {up_steps, dn_steps, prog_cycles, go_cnt, d_word, m_word} = '0;
        {ph_done_cnt, cg_done_cnt, err_cnt, check_fails, tests_failed} = '0;
        model_ph = 0;
        rows[0] = '{OP_PHASE,   20, 0, 0, 1'b0, 1'b0,  20, 0, 0, 0};
        rows[1] = '{OP_PHASE,  -15, 0, 0, 1'b0, 1'b0, -15, 0, 0, 0};
        rows[2] = '{OP_CLKGEN,   0, 5, 3, 1'b0, 1'b0, -15, 2, 4, 0};
        rows[3] = '{OP_BADCG,    0, 1, 4, 1'b0, 1'b0, -15, 0, 0, 1};
        rows[4] = '{OP_BADCG,    0, 6, 0, 1'b0, 1'b0, -15, 0, 0, 1};
        rows[5] = '{OP_BOTH,     7, 9, 2, 1'b0, 1'b0,   7, 1, 8, 0};
        rows[6] = '{OP_PHASE,   30, 0, 0, 1'b1, 1'b0,   7, 0, 0, 0};
        rows[7] = '{OP_PHASE,   12, 0, 0, 1'b0, 1'b1,   7, 0, 0, 0};
        rows[8] = '{OP_BURST,   -4, 0, 0, 1'b0, 1'b0,   4, 0, 0, 1}; // sixth load dropped
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            row_bad = 1'b0;
            {ph0, cg0, er0} = {ph_done_cnt, cg_done_cnt, err_cnt};
            {up0, dn0, pc0, go0} = {up_steps, dn_steps, prog_cycles, go_cnt};
            d_word = -1;
            m_word = -1;
            ps_ovf = r.ovf;
            hold_psdone = r.hold;
            phase_req = phase_w_t'(r.ph);
            mul = md_w_t'(r.mul);
            dv = md_w_t'(r.dv);
            phase_load = (r.op == OP_PHASE || r.op == OP_BOTH || r.op == OP_BURST);
            clkgen_load = (r.op == OP_CLKGEN || r.op == OP_BADCG || r.op == OP_BOTH);
            @(negedge clk);
            if (r.op == OP_BURST) begin
                for (int k = 1; k < FIFO_DEPTH + 2; k++) begin
                    phase_req = phase_w_t'(r.ph + 2 * k); // one load per cycle
                    @(negedge clk);
                end
            end
            phase_load = 1'b0;
            clkgen_load = 1'b0;
            want_ph = ph0 + ((r.op == OP_PHASE || r.op == OP_BOTH) ? 1 : 0);
            if (r.op == OP_BURST) want_ph = ph0 + FIFO_DEPTH + 1;
            want_cg = cg0 + ((r.op == OP_CLKGEN || r.op == OP_BOTH) ? 1 : 0);
            wait_counts(want_ph, want_cg, er0 + r.exp_err, ok);
            if (!ok) begin
                $display("test %0d: done or error pulse missing after %0d cycles", i, ROW_CYCLES);
                row_bad = 1'b1;
            end
            compare("busy_o with nothing queued", busy, 0);
            if (r.op == OP_BADCG) begin
                repeat (QUIET_CYCLES) @(negedge clk);   // room for a wrongly queued sequence
                compare("progen cycles after rejected load", prog_cycles - pc0, 0);
                compare("clkgen_done pulses", cg_done_cnt - cg0, 0);
            end
            compare("cmd_error pulses", err_cnt - er0, r.exp_err);
            compare("phase_actual_o", int'(phase_actual), r.exp_ph);
            if (r.op == OP_PHASE && !r.ovf && !r.hold) begin
                compare("increment steps", up_steps - up0,
                        (r.exp_ph > model_ph) ? r.exp_ph - model_ph : 0);
                compare("decrement steps", dn_steps - dn0,
                        (r.exp_ph < model_ph) ? model_ph - r.exp_ph : 0);
            end
            if (r.ovf) compare("steps under overflow", up_steps + dn_steps - up0 - dn0, 0);
            if (r.op == OP_CLKGEN || r.op == OP_BOTH) begin
                compare("captured D word", d_word, r.exp_d);
                compare("captured M word", m_word, r.exp_m);
                compare("go commands", go_cnt - go0, 1);
            end
            if (r.op == OP_BOTH) compare("phase done before clkgen done", ph_done_t < cg_done_t, 1);
            model_ph = r.exp_ph;
            ps_ovf = 1'b0;
            if (row_bad) tests_failed++;
            $display("test %0d op %0d: %s", i, r.op, row_bad ? "failed" : "ok");
        end
        asrt = dut_i.u_stepper.u_stepper_assert.fails + dut_i.u_fifo.u_fifo_assert.fails;
        $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 NUM_ROWS, tests_failed, check_fails, asrt);
        if (tests_failed == 0 && asrt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb/clk_mgmt_assert.sv
module clk_mgmt_assert #(
    parameter int PSDONE_TIMEOUT = 64                   // stepper wait limit in cycles
) (
    input logic clk_i,
    input logic reset_i,
    input logic psen_i,                                 // phase step enable
    input logic psdone_i,                               // dcm reply to a step
    input logic push_i,
    input logic full_i
);
    int   fails = 0;                                    // failed assertions in this instance
    logic step_open;                                    // step sent, no reply and no timeout yet
    int   open_cycles;                                  // cycles the open step has waited

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            step_open   <= 1'b0;
            open_cycles <= 0;
        end else if (psen_i) begin
            step_open   <= ~psdone_i;
            open_cycles <= 0;
        end else if (psdone_i || open_cycles == PSDONE_TIMEOUT) begin
            step_open <= 1'b0;                          // answered, or stepper gave up
        end else begin
            open_cycles <= open_cycles + 1;
        end
    end

    a_psen_single: assert property (@(posedge clk_i) disable iff (reset_i)
        psen_i |=> !psen_i)
        else begin
            $error("psen held high for more than one cycle");
            fails++;
        end

    a_psen_not_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        psen_i |-> !step_open)                          // previous step must be answered or timed out
        else begin
            $error("psen raised while the previous step was still waiting");
            fails++;
        end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> !full_i)
        else begin
            $error("command pushed into a full fifo");
            fails++;
        end

endmodule

bind dcm_phase_stepper clk_mgmt_assert #(.PSDONE_TIMEOUT(PSDONE_TIMEOUT)) u_stepper_assert (
    .clk_i,
    .reset_i,
    .psen_i   (psen_o),
    .psdone_i (psdone_i),
    .push_i   (1'b0),                                   // fifo side unused here
    .full_i   (1'b0)
);

bind clk_cmd_fifo clk_mgmt_assert u_fifo_assert (
    .clk_i,
    .reset_i,
    .psen_i   (1'b0),                                   // stepper side unused here
    .psdone_i (1'b0),
    .push_i   (push_i),
    .full_i   (full_o)
);

//--- hdl/clk_mgmt_ctrl_top.sv
module clk_mgmt_ctrl_top #(
    parameter int FIFO_DEPTH     = 4,                   // queued commands
    parameter int PSDONE_TIMEOUT = 64                   // psdone wait limit
) (
    input  logic                       clk_i,           // phase programming clock
    input  logic                       reset_i,
    input  logic                       phase_load_i,
    input  clk_mgmt_cfg_pkg::phase_w_t phase_requested_i,
    input  logic                       clkgen_load_i,
    input  clk_mgmt_cfg_pkg::md_w_t    clkgen_mul_i,
    input  clk_mgmt_cfg_pkg::md_w_t    clkgen_div_i,
    input  logic                       dcm_psdone_i,
    input  logic                       dcm_ps_overflow_i,
    input  logic                       dcm_progdone_i,
    output clk_mgmt_cfg_pkg::phase_w_t phase_actual_o,
    output logic                       phase_done_o,
    output logic                       clkgen_done_o,
    output logic                       cmd_error_o,
    output logic                       busy_o,
    output logic                       dcm_psen_o,
    output logic                       dcm_psincdec_o,
    output logic                       dcm_progen_o,
    output logic                       dcm_progdata_o
);
    import clk_mgmt_cmd_pkg::*;

    logic      push;
    logic      pop;
    logic      fifo_full;
    logic      fifo_not_empty;
    cmd_word_t iss_cmd;                                 // issuer to fifo
    cmd_word_t head_cmd;                                // fifo head to dispatcher

    dcm_job_if phase_job ();
    dcm_job_if clkgen_job ();

    clk_cmd_issuer u_issuer (
        .clk_i, .reset_i, .phase_load_i, .phase_requested_i,
        .clkgen_load_i, .clkgen_mul_i, .clkgen_div_i,
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .cmd_o       (iss_cmd),
        .cmd_error_o
    );

    clk_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_i, .reset_i,
        .push_i      (push),
        .cmd_i       (iss_cmd),
        .pop_i       (pop),
        .cmd_o       (head_cmd),
        .not_empty_o (fifo_not_empty),
        .full_o      (fifo_full)
    );

    dcm_cmd_dispatch u_dispatch (
        .clk_i, .reset_i,
        .cmd_i       (head_cmd),
        .not_empty_i (fifo_not_empty),
        .pop_o       (pop),
        .phase_done_o, .clkgen_done_o, .busy_o,
        .phase_job   (phase_job.master),
        .clkgen_job  (clkgen_job.master)
    );

    dcm_phase_stepper #(.PSDONE_TIMEOUT(PSDONE_TIMEOUT)) u_stepper (
        .clk_i, .reset_i,
        .psdone_i       (dcm_psdone_i),
        .ps_overflow_i  (dcm_ps_overflow_i),
        .psen_o         (dcm_psen_o),
        .psincdec_o     (dcm_psincdec_o),
        .phase_actual_o,
        .job            (phase_job.worker)
    );

    dcm_clkgen_loader u_loader (
        .clk_i, .reset_i,
        .progdone_i (dcm_progdone_i),
        .progen_o   (dcm_progen_o),
        .progdata_o (dcm_progdata_o),
        .job        (clkgen_job.worker)
    );

endmodule

//--- hdl/dcm_clkgen_loader.sv
module dcm_clkgen_loader (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      progdone_i,
    output logic      progen_o,
    output logic      progdata_o,
    dcm_job_if.worker job
);
    import clk_mgmt_cfg_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DWORD,                                       // lead-in d plus divide-1
        ST_GAP1,
        ST_MWORD,                                       // lead-in m plus multiply-1
        ST_GAP2,
        ST_GO,
        ST_WAIT                                         // hold for progdone
    } state_e;

    state_e                 state_q;
    logic [WORD_BITS-1:0]   shift_q;                    // serial word, lsb out first
    md_w_t                  mul_m1_q;                   // multiply-1 kept for second word
    logic [3:0]             cnt_q;                      // bit or gap counter
    logic                   word_end;
    logic                   gap_end;

    assign word_end = (cnt_q == 4'(WORD_BITS - 1));
    assign gap_end  = (cnt_q == 4'(CLKGEN_GAP - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (job.start) state_q <= ST_DWORD;
                end
                ST_DWORD: if (word_end) begin
                    cnt_q   <= '0;
                    state_q <= ST_GAP1;
                end
                ST_GAP1: if (gap_end) begin
                    cnt_q   <= '0;
                    state_q <= ST_MWORD;
                end
                ST_MWORD: if (word_end) begin
                    cnt_q   <= '0;
                    state_q <= ST_GAP2;
                end
                ST_GAP2: if (gap_end) begin
                    state_q <= ST_GO;
                end
                ST_GO:   state_q <= ST_WAIT;
                default: if (progdone_i) state_q <= ST_IDLE; // new m/d active
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && job.start) begin
            shift_q  <= {job.body.md.div - 8'd1, LEAD_D};
            mul_m1_q <= job.body.md.mul - 8'd1;
        end else if (state_q == ST_GAP1) begin
            shift_q  <= {mul_m1_q, LEAD_M};             // preload second word
        end else begin
            shift_q  <= shift_q >> 1;
        end
    end

    assign progen_o   = (state_q == ST_DWORD) || (state_q == ST_MWORD) || (state_q == ST_GO);
    assign progdata_o = ((state_q == ST_DWORD) || (state_q == ST_MWORD)) && shift_q[0];

    assign job.busy = (state_q != ST_IDLE);
    assign job.done = (state_q == ST_WAIT) && progdone_i;

endmodule

//--- hdl/dcm_phase_stepper.sv
module dcm_phase_stepper #(
    parameter int PSDONE_TIMEOUT = 64                   // cycles to wait for psdone
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       psdone_i,
    input  logic                       ps_overflow_i,
    output logic                       psen_o,
    output logic                       psincdec_o,
    output clk_mgmt_cfg_pkg::phase_w_t phase_actual_o,
    dcm_job_if.worker                  job
);
    import clk_mgmt_cfg_pkg::*;

    localparam int TW = $clog2(PSDONE_TIMEOUT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STEP,
        ST_WAIT,
        ST_FINISH
    } state_e;

    state_e          state_q;
    phase_w_t        target_q;                          // requested phase
    logic [TW-1:0]   tmo_q;                             // cycles spent in wait

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q        <= ST_IDLE;
            psen_o         <= 1'b0;
            psincdec_o     <= 1'b0;
            phase_actual_o <= '0;
            tmo_q          <= '0;
        end else begin
            psen_o <= 1'b0;                             // single cycle enable
            case (state_q)
                ST_IDLE: begin
                    if (job.start) state_q <= ST_STEP;
                end
                ST_STEP: begin
                    if (phase_actual_o == target_q || ps_overflow_i) begin
                        state_q <= ST_FINISH;           // reached, or dcm at its limit
                    end else begin
                        psen_o     <= 1'b1;
                        psincdec_o <= (target_q > phase_actual_o); // 1 = increment
                        tmo_q      <= '0;
                        state_q    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    tmo_q <= tmo_q + 1'b1;
                    if (psdone_i) begin
                        if (psincdec_o) phase_actual_o <= phase_actual_o + 1'b1;
                        else            phase_actual_o <= phase_actual_o - 1'b1;
                        state_q <= ST_STEP;
                    end else if (tmo_q == TW'(PSDONE_TIMEOUT - 1)) begin
                        state_q <= ST_FINISH;           // no reply, give up on this step
                    end
                end
                default: state_q <= ST_IDLE;            // finish lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && job.start) target_q <= job.body.phase[PHASE_W-1:0];
    end

    assign job.busy = (state_q != ST_IDLE);
    assign job.done = (state_q == ST_FINISH);

endmodule

//--- hdl/dcm_cmd_dispatch.sv
module dcm_cmd_dispatch (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  clk_mgmt_cmd_pkg::cmd_word_t cmd_i,
    input  logic                        not_empty_i,
    output logic                        pop_o,
    output logic                        phase_done_o,
    output logic                        clkgen_done_o,
    output logic                        busy_o,
    dcm_job_if.master                   phase_job,
    dcm_job_if.master                   clkgen_job
);
    import clk_mgmt_cmd_pkg::*;

    logic inflight_q;                                   // one command at a time
    logic engines_free;
    logic is_phase;

    assign engines_free = ~phase_job.busy & ~clkgen_job.busy;
    assign is_phase     = (cmd_i.kind == CMD_PHASE);

    // pop and launch in the same cycle
    assign pop_o = not_empty_i & ~inflight_q & engines_free;

    assign phase_job.start  = pop_o & is_phase;
    assign clkgen_job.start = pop_o & ~is_phase;
    assign phase_job.body   = cmd_i.body;               // union goes through whole
    assign clkgen_job.body  = cmd_i.body;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            inflight_q    <= 1'b0;
            phase_done_o  <= 1'b0;
            clkgen_done_o <= 1'b0;
        end else begin
            phase_done_o  <= phase_job.done;            // one cycle after worker done
            clkgen_done_o <= clkgen_job.done;
            if (pop_o) begin
                inflight_q <= 1'b1;
            end else if (phase_done_o | clkgen_done_o) begin
                inflight_q <= 1'b0;                     // idle the cycle after the pulse
            end
        end
    end

    assign busy_o = inflight_q | not_empty_i;           // work running or queued

endmodule

//--- hdl/clk_cmd_fifo.sv
module clk_cmd_fifo #(
    parameter int FIFO_DEPTH = 4                        // power of two
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        push_i,
    input  clk_mgmt_cmd_pkg::cmd_word_t cmd_i,
    input  logic                        pop_i,
    output clk_mgmt_cmd_pkg::cmd_word_t cmd_o,
    output logic                        not_empty_o,
    output logic                        full_o
);
    import clk_mgmt_cmd_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    cmd_word_t     mem [FIFO_DEPTH];                    // command storage
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;                             // fill level, 0..FIFO_DEPTH
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i & ~full_o;                  // never overwrite
    assign do_pop  = pop_i & not_empty_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;            // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr_q] <= cmd_i;
    end

    assign cmd_o       = mem[rd_ptr_q];                 // fall-through head
    assign not_empty_o = (count_q != '0);
    assign full_o      = (count_q == (AW + 1)'(FIFO_DEPTH));

endmodule

//--- hdl/clk_cmd_issuer.sv
module clk_cmd_issuer (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        phase_load_i,
    input  clk_mgmt_cfg_pkg::phase_w_t  phase_requested_i,
    input  logic                        clkgen_load_i,
    input  clk_mgmt_cfg_pkg::md_w_t     clkgen_mul_i,
    input  clk_mgmt_cfg_pkg::md_w_t     clkgen_div_i,
    input  logic                        fifo_full_i,
    output logic                        push_o,
    output clk_mgmt_cmd_pkg::cmd_word_t cmd_o,
    output logic                        cmd_error_o
);
    import clk_mgmt_cmd_pkg::*;

    logic      ph_v_q;                                  // phase command staged
    logic      cg_v_q;                                  // clkgen command staged
    logic      bad_q;                                   // rejected m/d request
    cmd_word_t ph_cmd_q;
    cmd_word_t cg_cmd_q;
    logic      cg_ok;

    assign cg_ok = (clkgen_mul_i >= 8'd2) && (clkgen_div_i != 8'd0); // dcm m/d limits

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ph_v_q <= 1'b0;
            cg_v_q <= 1'b0;
            bad_q  <= 1'b0;
        end else begin
            ph_v_q <= phase_load_i;
            bad_q  <= clkgen_load_i & ~cg_ok;
            if (clkgen_load_i) begin
                cg_v_q <= cg_ok;
            end else if (!ph_v_q) begin
                cg_v_q <= 1'b0;                         // issued this cycle, unless phase went first
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (phase_load_i) begin
            ph_cmd_q.kind       <= CMD_PHASE;
            ph_cmd_q.body.phase <= phase_requested_i;   // signed, so sign extends
        end
        if (clkgen_load_i) begin
            cg_cmd_q.kind        <= CMD_CLKGEN;
            cg_cmd_q.body.md.mul <= clkgen_mul_i;
            cg_cmd_q.body.md.div <= clkgen_div_i;
        end
    end

    assign cmd_o       = ph_v_q ? ph_cmd_q : cg_cmd_q;  // phase has priority
    assign push_o      = (ph_v_q | cg_v_q) & ~fifo_full_i;
    assign cmd_error_o = bad_q | ((ph_v_q | cg_v_q) & fifo_full_i); // dropped request

endmodule

//--- hdl/dcm_job_if.sv
interface dcm_job_if;

    logic                         start;                // one cycle job launch
    clk_mgmt_cmd_pkg::cmd_body_u  body;                 // valid with start
    logic                         busy;                 // worker engaged
    logic                         done;                 // one cycle completion

    modport master (
        output start,
        output body,
        input  busy,
        input  done
    );

    modport worker (
        input  start,
        input  body,
        output busy,
        output done
    );

endinterface

//--- hdl/clk_mgmt_cmd_pkg.sv
package clk_mgmt_cmd_pkg;

    typedef enum logic {
        CMD_PHASE  = 1'b0,                              // step the phase shifter
        CMD_CLKGEN = 1'b1                               // reprogram generated clock
    } cmd_kind_e;

    typedef struct packed {
        clk_mgmt_cfg_pkg::md_w_t mul;                   // multiply as requested
        clk_mgmt_cfg_pkg::md_w_t div;                   // divide as requested
    } md_pair_t;

    // one 16 bit body, read by whichever engine the kind selects
    typedef union packed {
        logic signed [15:0] phase;                      // phase target, sign extended
        md_pair_t           md;                         // multiply / divide pair
    } cmd_body_u;

    typedef struct packed {
        cmd_kind_e kind;                                // selects the engine
        cmd_body_u body;                                // payload for that engine
    } cmd_word_t;

endpackage

//--- hdl/clk_mgmt_cfg_pkg.sv
package clk_mgmt_cfg_pkg;

    localparam int PHASE_W = 9;                         // dcm phase range -255..255
    localparam int MD_W    = 8;                         // user multiply / divide width

    typedef logic signed [PHASE_W-1:0] phase_w_t;       // signed phase value
    typedef logic        [MD_W-1:0]    md_w_t;          // multiply or divide as given

    // programming stream of the generated clock, all bits lsb first
    localparam int         LEAD_W     = 2;              // lead-in bit pair
    localparam logic [1:0] LEAD_D     = 2'b01;          // load d: 1 then 0
    localparam logic [1:0] LEAD_M     = 2'b11;          // load m: 1 then 1
    localparam int         WORD_BITS  = LEAD_W + MD_W;  // lead-in plus value, 10 cycles
    localparam int         CLKGEN_GAP = 2;              // idle cycles between words

endpackage
